/* bconv_pkg.sv */
// binary conv engine shared widths, constants and stage-to-stage structs
package bconv_pkg;

	// ==================================================
	// widths and constants
	// ==================================================
	// data word, also the widest matrix
	localparam int word_w = 16;
	// fixed square kernel
	localparam int kernel_dim = 3;
	localparam int kernel_taps = kernel_dim * kernel_dim;
	// row-count value that closes a run
	localparam logic [word_w-1:0] end_marker = 16'h00FF;
	// highest mismatch total still giving a 1
	localparam int mismatch_limit = 4;
	// window out of fetch to write pulse
	localparam int pipe_depth = 3;

	// ==================================================
	// types
	// ==================================================
	typedef logic [word_w-1:0] word_t;
	typedef logic [$clog2(word_w)-1:0] col_idx_t;

	// one window per cycle from fetch into count
	// tap 3k+j is row k, column col+j, already xor'd with the weight
	typedef struct packed {
		logic valid;
		logic [kernel_taps-1:0] taps;
		col_idx_t col;
		// last valid column of the output row
		logic row_last;
		// first window after dut_run
		logic run_first;
	} window_t;

	// thresholded bit from count into the writer
	typedef struct packed {
		logic valid;
		// 1 when mismatches <= mismatch_limit
		logic out_bit;
		col_idx_t col;
		logic row_last;
	} result_t;

endpackage

/* bconv_window_fetch.sv */
// conv fetch stage, runs the matrix sequence and streams mismatch windows
`timescale 1ns/1ps

module bconv_window_fetch
	import bconv_pkg::*;
#(
	parameter int addr_w = 12
) (
	input  logic clk,
	input  logic reset_b,
	input  logic dut_run,
	output logic dut_busy,
	output logic [addr_w-1:0] dut_sram_read_address,
	input  word_t sram_dut_read_data,
	output logic [addr_w-1:0] dut_wmem_read_address,
	input  word_t wmem_dut_read_data,
	output window_t window
);

	typedef enum logic [2:0] {
		st_idle,
		st_hdr,
		st_rows,
		st_cols,
		st_load,
		st_sweep,
		st_shift,
		st_drain
	} state_t;

	localparam int drain_w = $clog2(pipe_depth + 1);
	typedef logic [drain_w-1:0] drain_t;

	state_t state;
	logic [addr_w-1:0] rd_addr;
	// row shifts still to do in this matrix
	word_t rows_left;
	col_idx_t last_col;
	col_idx_t col;
	logic [1:0] load_cnt;
	drain_t drain_cnt;
	logic first_pend;

	// row buffers, index 0 is the top kernel row
	logic [kernel_dim-1:0][word_w-1:0] rows_q;
	logic [kernel_taps-1:0] weight;
	logic [kernel_dim-1:0][word_w-1:0] shifted;
	logic [kernel_taps-1:0] mism;

	// input sram, one read in flight, data back next cycle
	assign dut_sram_read_address = rd_addr;
	// weights always at address 0
	assign dut_wmem_read_address = '0;

	// ==================================================
	// window taps
	// ==================================================
	always_comb begin
		for (int k = 0; k < kernel_dim; k++) begin
			// bring column col down to bit 0
			shifted[k] = rows_q[k] >> col;
			mism[k*kernel_dim +: kernel_dim] =
				shifted[k][kernel_dim-1:0] ^ weight[k*kernel_dim +: kernel_dim];
		end
	end

	// ==================================================
	// run control
	// ==================================================
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			state <= st_idle;
			dut_busy <= 1'b0;
			rd_addr <= '0;
			rows_left <= '0;
			last_col <= '0;
			col <= '0;
			load_cnt <= '0;
			drain_cnt <= '0;
			first_pend <= 1'b0;
			window <= '0;
		end else begin
			// window only valid in sweep
			window.valid <= 1'b0;
			window.run_first <= 1'b0;
			case (state)
				st_idle: begin
					// run ignored unless idle
					if (dut_run) begin
						dut_busy <= 1'b1;
						rd_addr <= '0;
						first_pend <= 1'b1;
						state <= st_hdr;
					end
				end
				st_hdr: begin
					// row-count address on the bus, step to cols
					rd_addr <= rd_addr + 1'b1;
					state <= st_rows;
				end
				st_rows: begin
					if (sram_dut_read_data == end_marker) begin
						// let count and writer empty out
						drain_cnt <= drain_t'(pipe_depth);
						state <= st_drain;
					end else begin
						rows_left <= sram_dut_read_data - word_t'(kernel_dim);
						rd_addr <= rd_addr + 1'b1;
						state <= st_cols;
					end
				end
				st_cols: begin
					// last start column is cols-3
					last_col <= col_idx_t'(sram_dut_read_data - word_t'(kernel_dim));
					rd_addr <= rd_addr + 1'b1;
					load_cnt <= '0;
					state <= st_load;
				end
				st_load: begin
					// third load leaves the address on the next row
					if (load_cnt == 2'(kernel_dim - 1)) begin
						col <= '0;
						state <= st_sweep;
					end else begin
						load_cnt <= load_cnt + 1'b1;
						rd_addr <= rd_addr + 1'b1;
					end
				end
				st_sweep: begin
					window.valid <= 1'b1;
					window.taps <= mism;
					window.col <= col;
					window.row_last <= (col == last_col);
					window.run_first <= first_pend;
					first_pend <= 1'b0;
					if (col == last_col) begin
						col <= '0;
						// out of rows, next header is already addressed
						state <= (rows_left == '0) ? st_hdr : st_shift;
					end else begin
						col <= col + 1'b1;
					end
				end
				st_shift: begin
					// next row sat on the bus during the sweep
					rows_left <= rows_left - 1'b1;
					rd_addr <= rd_addr + 1'b1;
					state <= st_sweep;
				end
				st_drain: begin
					if (drain_cnt == drain_t'(1)) begin
						dut_busy <= 1'b0;
						state <= st_idle;
					end else begin
						drain_cnt <= drain_cnt - 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// row buffers and weights
	always_ff @(posedge clk) begin
		if (state == st_cols) begin
			weight <= wmem_dut_read_data[kernel_taps-1:0];
		end
		// shift up, new row in at the bottom
		if (state == st_load || state == st_shift) begin
			rows_q <= {sram_dut_read_data, rows_q[kernel_dim-1:1]};
		end
	end

endmodule

/* bconv_popcount_threshold.sv */
// conv count stage, two-cycle mismatch popcount and majority threshold
`timescale 1ns/1ps

module bconv_popcount_threshold
	import bconv_pkg::*;
(
	input  logic clk,
	input  logic reset_b,
	input  window_t window,
	output result_t result
);

	typedef logic [$clog2(kernel_dim + 1)-1:0] row_cnt_t;
	typedef logic [$clog2(kernel_taps + 1)-1:0] sum_t;

	row_cnt_t [kernel_dim-1:0] row_cnt_d;
	row_cnt_t [kernel_dim-1:0] row_cnt_q;
	sum_t total;

	// stage 1 sidebands
	logic s1_valid;
	col_idx_t s1_col;
	logic s1_row_last;

	// ==================================================
	// stage 1, per kernel row counts
	// ==================================================
	always_comb begin
		row_cnt_d = '0;
		for (int k = 0; k < kernel_dim; k++) begin
			for (int j = 0; j < kernel_dim; j++) begin
				row_cnt_d[k] = row_cnt_d[k] + row_cnt_t'(window.taps[k*kernel_dim + j]);
			end
		end
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= window.valid;
		end
	end

	always_ff @(posedge clk) begin
		row_cnt_q <= row_cnt_d;
		s1_col <= window.col;
		s1_row_last <= window.row_last;
	end

	// ==================================================
	// stage 2, total and threshold
	// ==================================================
	always_comb begin
		total = '0;
		for (int k = 0; k < kernel_dim; k++) begin
			total = total + sum_t'(row_cnt_q[k]);
		end
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			result <= '0;
		end else begin
			result.valid <= s1_valid;
			// majority match
			result.out_bit <= (total <= sum_t'(mismatch_limit));
			result.col <= s1_col;
			result.row_last <= s1_row_last;
		end
	end

endmodule

/* bconv_row_writer.sv */
// conv write-back stage, packs result bits into row words for the output sram
`timescale 1ns/1ps

module bconv_row_writer
	import bconv_pkg::*;
#(
	parameter int addr_w = 12
) (
	input  logic clk,
	input  logic reset_b,
	input  result_t result,
	input  logic run_first,
	output logic [addr_w-1:0] dut_sram_write_address,
	output word_t dut_sram_write_data,
	output logic dut_sram_write_enable
);

	// next output row address, runs across matrices
	logic [addr_w-1:0] wr_addr;
	// bits of the row being built
	word_t row_acc;
	// finished row word including the closing bit
	word_t row_word;

	// last column's bit goes straight into the write data
	assign row_word = row_acc | (word_t'(result.out_bit) << result.col);

	// ==================================================
	// accumulate and write
	// ==================================================
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			wr_addr <= '0;
			row_acc <= '0;
			dut_sram_write_enable <= 1'b0;
		end else begin
			// single-cycle pulse
			dut_sram_write_enable <= 1'b0;
			// first window is two cycles ahead of its result
			if (run_first) begin
				wr_addr <= '0;
			end
			if (result.valid) begin
				if (result.row_last) begin
					dut_sram_write_enable <= 1'b1;
					wr_addr <= wr_addr + 1'b1;
					// cleared so bits past cols-3 stay 0
					row_acc <= '0;
				end else begin
					row_acc[result.col] <= result.out_bit;
				end
			end
		end
	end

	// write payload, only sampled with the enable
	always_ff @(posedge clk) begin
		if (result.valid && result.row_last) begin
			dut_sram_write_address <= wr_addr;
			dut_sram_write_data <= row_word;
		end
	end

endmodule

/* bconv_top.sv */
// binary 3x3 conv engine top, fetch, count and write-back on the sram ports
`timescale 1ns/1ps

module bconv_top
	import bconv_pkg::*;
#(
	parameter int addr_w = 12
) (
	input  logic clk,
	input  logic reset_b,
	input  logic dut_run,
	output logic dut_busy,
	output logic [addr_w-1:0] dut_sram_read_address,
	input  word_t sram_dut_read_data,
	output logic [addr_w-1:0] dut_wmem_read_address,
	input  word_t wmem_dut_read_data,
	output logic [addr_w-1:0] dut_sram_write_address,
	output word_t dut_sram_write_data,
	output logic dut_sram_write_enable
);

	// fetch to count
	window_t window_s;
	// count to writer
	result_t result_s;

	bconv_window_fetch #(
		.addr_w(addr_w)
	) i_fetch (
		.clk(clk),
		.reset_b(reset_b),
		.dut_run(dut_run),
		.dut_busy(dut_busy),
		.dut_sram_read_address(dut_sram_read_address),
		.sram_dut_read_data(sram_dut_read_data),
		.dut_wmem_read_address(dut_wmem_read_address),
		.wmem_dut_read_data(wmem_dut_read_data),
		.window(window_s)
	);

	bconv_popcount_threshold i_count (
		.clk(clk),
		.reset_b(reset_b),
		.window(window_s),
		.result(result_s)
	);

	// address restart taken from the window, ahead of its result
	bconv_row_writer #(
		.addr_w(addr_w)
	) i_writer (
		.clk(clk),
		.reset_b(reset_b),
		.result(result_s),
		.run_first(window_s.run_first),
		.dut_sram_write_address(dut_sram_write_address),
		.dut_sram_write_data(dut_sram_write_data),
		.dut_sram_write_enable(dut_sram_write_enable)
	);

endmodule

/* bconv_checker.sv */
// conv engine checker, run handshake and output write ordering assertions
`timescale 1ns/1ps

module bconv_checker #(
	parameter int addr_w = 12
) (
	input logic clk,
	input logic reset_b,
	input logic dut_run,
	input logic dut_busy,
	input logic [addr_w-1:0] dut_sram_write_address,
	input logic dut_sram_write_enable
);

	// previous write address in this run
	logic [addr_w-1:0] last_addr;
	logic wrote;
	int assert_fails = 0;

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			last_addr <= '0;
			wrote <= 1'b0;
		end else if (dut_run && !dut_busy) begin
			// fresh run, output restarts at 0
			wrote <= 1'b0;
		end else if (dut_sram_write_enable) begin
			last_addr <= dut_sram_write_address;
			wrote <= 1'b1;
		end
	end

	no_write_idle: assert property (@(posedge clk) disable iff (!reset_b)
		dut_sram_write_enable |-> dut_busy)
		else begin
			$error("output write while engine idle");
			assert_fails++;
		end

	busy_from_run: assert property (@(posedge clk) disable iff (!reset_b)
		$rose(dut_busy) |-> $past(dut_run && !dut_busy))
		else begin
			$error("busy rose without a run pulse while idle");
			assert_fails++;
		end

	run_starts: assert property (@(posedge clk) disable iff (!reset_b)
		(dut_run && !dut_busy) |=> dut_busy)
		else begin
			$error("run pulse while idle did not set busy");
			assert_fails++;
		end

	// 0 first, then one up per write
	addr_in_order: assert property (@(posedge clk) disable iff (!reset_b)
		dut_sram_write_enable |->
		dut_sram_write_address == (wrote ? addr_w'(last_addr + 1'b1) : '0))
		else begin
			$error("output write address out of sequence");
			assert_fails++;
		end

endmodule

bind bconv_top bconv_checker #(
	.addr_w(addr_w)
) i_checker (
	.clk(clk),
	.reset_b(reset_b),
	.dut_run(dut_run),
	.dut_busy(dut_busy),
	.dut_sram_write_address(dut_sram_write_address),
	.dut_sram_write_enable(dut_sram_write_enable)
);

/* tb_bconv.sv */
// testbench for the binary 3x3 conv engine, case table checked against a reference model
`timescale 1ns/1ps

module tb_bconv;
	import bconv_pkg::*;

	localparam int addr_w = 12;
	localparam int mem_depth = 1 << addr_w;
	localparam int n_cases = 7;

	// data modes of a table entry
	localparam logic [1:0] mode_rand = 2'd0;
	localparam logic [1:0] mode_ones = 2'd1;
	localparam logic [1:0] mode_zeros = 2'd2;
	localparam logic [1:0] mode_expl = 2'd3;

	// one table entry, up to three matrices per run
	typedef struct packed {
		logic [15:0] weight;
		logic [1:0] n_mat;
		logic [2:0][7:0] rows;
		logic [2:0][7:0] cols;
		logic [1:0] mode;
	} case_t;

	logic clk;
	logic reset_b;
	logic dut_run;
	logic dut_busy;
	logic [addr_w-1:0] dut_sram_read_address;
	word_t sram_dut_read_data;
	logic [addr_w-1:0] dut_wmem_read_address;
	word_t wmem_dut_read_data;
	logic [addr_w-1:0] dut_sram_write_address;
	word_t dut_sram_write_data;
	logic dut_sram_write_enable;

	// memory models
	word_t in_mem [0:mem_depth-1];
	word_t w_mem [0:mem_depth-1];
	word_t out_mem [0:mem_depth-1];
	int write_count;

	case_t cases [n_cases];
	// zero weight, window 0 sees 4 ones and window 1 sees 5
	word_t expl_rows [3] = '{16'h0006, 16'h0006, 16'h0008};
	word_t exp_q [$];
	int seed = 32'h03d7_09da;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycle_limit;

	bconv_top #(
		.addr_w(addr_w)
	) i_dut (
		.clk(clk),
		.reset_b(reset_b),
		.dut_run(dut_run),
		.dut_busy(dut_busy),
		.dut_sram_read_address(dut_sram_read_address),
		.sram_dut_read_data(sram_dut_read_data),
		.dut_wmem_read_address(dut_wmem_read_address),
		.wmem_dut_read_data(wmem_dut_read_data),
		.dut_sram_write_address(dut_sram_write_address),
		.dut_sram_write_data(dut_sram_write_data),
		.dut_sram_write_enable(dut_sram_write_enable)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==================================================
	// memory models and cycle limit
	// ==================================================
	// address taken at the edge, data back 10 ns later
	always @(posedge clk) begin
		sram_dut_read_data <= #10 in_mem[dut_sram_read_address];
		wmem_dut_read_data <= #10 w_mem[dut_wmem_read_address];
		if (dut_sram_write_enable) begin
			out_mem[dut_sram_write_address] <= dut_sram_write_data;
			write_count <= write_count + 1;
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout, run did not finish within %0d cycles", cycle_limit);
			$display("** FAIL **");
			$finish;
		end
	end

	// ==================================================
	// helpers
	// ==================================================
	function automatic case_t make_case(input word_t weight, input int r0, input int c0,
		input int r1, input int c1, input int r2, input int c2, input logic [1:0] mode);
		case_t tc;
		tc.weight = weight;
		tc.rows[0] = 8'(r0);
		tc.cols[0] = 8'(c0);
		tc.rows[1] = 8'(r1);
		tc.cols[1] = 8'(c1);
		tc.rows[2] = 8'(r2);
		tc.cols[2] = 8'(c2);
		// unused slots have zero rows
		tc.n_mat = 2'(int'(r0 != 0) + int'(r1 != 0) + int'(r2 != 0));
		tc.mode = mode;
		return tc;
	endfunction

	// bit c set when at most 4 of the 9 taps differ from the weight
	function automatic word_t expected_row_word(input word_t w, input word_t r0,
		input word_t r1, input word_t r2, input int cols);
		word_t rw [3];
		word_t row_word;
		int mism;
		rw[0] = r0;
		rw[1] = r1;
		rw[2] = r2;
		row_word = '0;
		for (int c = 0; c <= cols - 3; c++) begin
			mism = 0;
			// weight bit 3k+j against row k, column c+j
			for (int k = 0; k < 3; k++) begin
				for (int j = 0; j < 3; j++) begin
					mism += rw[k][c + j] ^ w[3 * k + j];
				end
			end
			if (mism <= 4) begin
				row_word[c] = 1'b1;
			end
		end
		return row_word;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	// fills the memories and builds the expected row words
	task automatic load_case(input case_t tc);
		int addr;
		word_t mat [0:15];
		addr = 0;
		for (int a = 0; a < mem_depth; a++) begin
			in_mem[a] = word_t'(a) ^ 16'h5a5a;
			w_mem[a] = word_t'(a) ^ 16'h3c3c;
			out_mem[a] = word_t'(a) ^ 16'hc3c3;
		end
		w_mem[0] = tc.weight;
		exp_q.delete();
		for (int m = 0; m < tc.n_mat; m++) begin
			in_mem[addr] = 16'(tc.rows[m]);
			in_mem[addr + 1] = 16'(tc.cols[m]);
			addr += 2;
			for (int r = 0; r < tc.rows[m]; r++) begin
				case (tc.mode)
					mode_rand: mat[r] = word_t'($random(seed));
					mode_ones: mat[r] = '1;
					mode_zeros: mat[r] = '0;
					default: mat[r] = expl_rows[r];
				endcase
				in_mem[addr] = mat[r];
				addr++;
			end
			for (int r = 0; r + 2 < tc.rows[m]; r++) begin
				exp_q.push_back(expected_row_word(tc.weight, mat[r], mat[r + 1],
					mat[r + 2], tc.cols[m]));
			end
		end
		// end marker closes the run
		in_mem[addr] = 16'h00ff;
	endtask

	// one-cycle run pulse, then wait for busy to drop
	task automatic run_engine();
		write_count = 0;
		dut_run = 1'b1;
		@(posedge clk);
		#10;
		dut_run = 1'b0;
		compare_value("dut_busy", 1, dut_busy);
		while (dut_busy) begin
			@(posedge clk);
			#10;
		end
	endtask

	task automatic check_outputs();
		compare_value("write_count", exp_q.size(), write_count);
		for (int i = 0; i < exp_q.size(); i++) begin
			compare_value($sformatf("dut_sram_write_data[%0d]", i), exp_q[i], out_mem[i]);
		end
	endtask

	// ==================================================
	// case table and main sequence
	// ==================================================
	initial begin
		reset_b = 1'b0;
		dut_run = 1'b0;
		sram_dut_read_data = '0;
		wmem_dut_read_data = '0;
		cases[0] = make_case(16'h0135, 8, 10, 0, 0, 0, 0, mode_rand);
		cases[1] = make_case(16'h01a6, 5, 7, 3, 16, 6, 4, mode_rand);
		cases[2] = make_case(16'h0000, 3, 4, 0, 0, 0, 0, mode_expl);
		cases[3] = make_case(16'h01ab, 3, 3, 0, 0, 0, 0, mode_ones);
		cases[4] = make_case(16'h0155, 16, 16, 0, 0, 0, 0, mode_rand);
		// end marker at address 0
		cases[5] = make_case(16'h0000, 0, 0, 0, 0, 0, 0, mode_zeros);
		cases[6] = make_case(16'h01ff, 4, 5, 0, 0, 0, 0, mode_zeros);
		cycle_limit = 0;
		for (int i = 0; i < n_cases; i++) begin
			for (int m = 0; m < cases[i].n_mat; m++) begin
				cycle_limit += cases[i].rows[m] * (cases[i].cols[m] + 8) + 100;
			end
		end
		repeat (2) @(posedge clk);
		#10;
		reset_b = 1'b1;
		for (int i = 0; i < n_cases; i++) begin
			load_case(cases[i]);
			@(posedge clk);
			#10;
			run_engine();
			check_outputs();
		end
		$display("checks %0d, value errors %0d, assertion failures %0d", checks, errors,
			i_dut.i_checker.assert_fails);
		if (errors == 0 && i_dut.i_checker.assert_fails == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* project.f */
bconv_pkg.sv
bconv_window_fetch.sv
bconv_popcount_threshold.sv
bconv_row_writer.sv
bconv_top.sv
bconv_checker.sv
tb_bconv.sv

/* Bender.yml */
package:
  name: bconv

sources:
  # design, package first
  - bconv_pkg.sv
  - bconv_window_fetch.sv
  - bconv_popcount_threshold.sv
  - bconv_row_writer.sv
  - bconv_top.sv
  # verification
  - target: simulation
    files:
      - bconv_checker.sv
      - tb_bconv.sv
